/* rtl/flitDeserializer.sv */
`timescale 1ns/1ps

module flitDeserializer (
	input logic sysClk,
	input logic rstN,
	input logic flush,
	input linkPkg::flitT in,
	input logic queueFull,
	output logic inReady,
	output logic wordPush,
	output logic [31:0] wordData
);

	linkPkg::flitIdxT flitCount;            // flits already taken for this word
	logic [linkPkg::linkBits-1:0] acc;      // newest flit enters at the top
	logic wordReady;                        // complete word waiting for the queue
	logic xfer;
	logic lastXfer;

	// stall the link only while a finished word is stuck behind a full queue
	assign inReady = !(wordReady && queueFull);
	assign xfer = in.valid && inReady;
	assign lastXfer = xfer && (flitCount == linkPkg::lastFlit);

	assign wordPush = wordReady && !queueFull;
	assign wordData = acc[31:0];   // bit 32 is bit 10 of flit 2, dropped

	// --------------------------------------------------
	// flit counter and word flag
	// --------------------------------------------------

	always_ff @(posedge sysClk) begin
		if (!rstN || flush) begin
			flitCount <= '0;
			wordReady <= 1'b0;
		end else begin
			if (xfer) begin
				flitCount <= lastXfer ? '0 : flitCount + 1'b1;
			end
			if (lastXfer) begin
				wordReady <= 1'b1;   // push goes out next cycle
			end else if (wordPush) begin
				wordReady <= 1'b0;
			end
		end
	end

	// shift accumulator, three shifts leave flit 0 at the bottom
	always_ff @(posedge sysClk) begin
		if (xfer) begin
			acc <= {in.data, acc[linkPkg::linkBits-1:linkPkg::flitWidth]};
		end
	end

endmodule

/* rtl/flitSerializer.sv */
`timescale 1ns/1ps

module flitSerializer (
	input logic sysClk,
	input logic rstN,
	input logic flush,
	input logic enable,
	input logic wordEmpty,
	input logic [31:0] wordHead,
	input logic outReady,
	output logic wordPop,
	output linkPkg::flitT out
);

	typedef enum logic {
		idle,
		sending
	} stateE;

	stateE state;
	linkPkg::flitIdxT flitIdx;   // flit now on the wire
	logic [31:0] shiftReg;       // unsent bits, next flit at the bottom
	logic xfer;

	// load only between words, a started word always finishes
	assign wordPop = (state == idle) && enable && !wordEmpty && !flush;
	assign xfer = out.valid && outReady;

	assign out.valid = (state == sending);
	assign out.data = shiftReg[linkPkg::flitWidth-1:0];   // zeros fill bit 10 of flit 2

	// --------------------------------------------------
	// state and flit index
	// --------------------------------------------------

	always_ff @(posedge sysClk) begin
		if (!rstN || flush) begin
			state <= idle;
			flitIdx <= '0;
		end else begin
			case (state)
				idle: begin
					if (wordPop) begin
						state <= sending;
						flitIdx <= '0;
					end
				end
				sending: begin
					if (xfer && flitIdx == linkPkg::lastFlit) begin
						state <= idle;   // third flit taken
						flitIdx <= '0;
					end else if (xfer) begin
						flitIdx <= flitIdx + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// word path, shifts one flit per transfer
	always_ff @(posedge sysClk) begin
		if (wordPop) begin
			shiftReg <= wordHead;
		end else if (xfer) begin
			shiftReg <= shiftReg >> linkPkg::flitWidth;
		end
	end

	// a stalled flit sits still until the far side takes it
	stallHold: assert property (@(posedge sysClk) disable iff (!rstN || flush)
		out.valid && !outReady |=> out.valid && $stable(out.data));

endmodule

/* rtl/hostCore.sv */
`timescale 1ns/1ps

module hostCore (
	input logic sysClk,
	input logic rstN,
	input logic pipeInWrite,
	input logic [31:0] pipeInData,
	input logic pipeOutRead,
	input logic topOutReady,
	input linkPkg::flitT topIn,
	output logic pipeInReady,
	output logic [31:0] pipeOutData,
	output logic pipeOutEmpty,
	output linkPkg::flitT topOut,
	output logic topInReady
);

	logic regWrite;
	hostPkg::regWriteT regWord;
	logic packetPush;
	logic [31:0] packetData;
	logic linkEnable;
	logic loopback;
	logic softReset;
	logic outEmpty;
	logic outFull;
	logic [31:0] outHead;
	logic outPop;
	linkPkg::flitT serOut;
	logic serReady;
	linkPkg::flitT desIn;
	logic desReady;
	logic desPush;
	logic [31:0] desData;
	logic pipeOutFull;

	// hold off while a packet is still in the decoder stage
	assign pipeInReady = !outFull && !packetPush;

	hostWordDecoder decoder (.sysClk, .rstN, .pipeInWrite, .pipeInData,
		.regWrite, .regWord, .packetPush, .packetData);

	hostRegisters registers (.sysClk, .rstN, .regWrite, .regWord,
		.linkEnable, .loopback, .softReset);

	wordFifo outQueue (.sysClk, .rstN, .flush(softReset), .push(packetPush),
		.pushData(packetData), .pop(outPop), .headData(outHead), .empty(outEmpty),
		.full(outFull));

	flitSerializer serializer (.sysClk, .rstN, .flush(softReset), .enable(linkEnable),
		.wordEmpty(outEmpty), .wordHead(outHead), .outReady(serReady), .wordPop(outPop),
		.out(serOut));

	// --------------------------------------------------
	// loopback mux
	// --------------------------------------------------

	always_comb begin
		if (loopback) begin
			desIn = serOut;       // serializer straight into deserializer
			serReady = desReady;
			topOut = '{data: serOut.data, valid: 1'b0};
			topInReady = 1'b0;    // neighbour sees us busy
		end else begin
			desIn = topIn;
			serReady = topOutReady;
			topOut = serOut;
			topInReady = desReady;
		end
	end

	flitDeserializer deserializer (.sysClk, .rstN, .flush(softReset), .in(desIn),
		.queueFull(pipeOutFull), .inReady(desReady), .wordPush(desPush), .wordData(desData));

	// reads on an empty queue are dropped here
	wordFifo pipeOutQueue (.sysClk, .rstN, .flush(softReset), .push(desPush),
		.pushData(desData), .pop(pipeOutRead && !pipeOutEmpty), .headData(pipeOutData),
		.empty(pipeOutEmpty), .full(pipeOutFull));

endmodule

/* rtl/hostPkg.sv */
package hostPkg;

	// --------------------------------------------------
	// host word layout
	// --------------------------------------------------

	// codes in bits 31:30 of a pipe-in word
	localparam logic [1:0] codeRegWrite = 2'b10;
	localparam logic [1:0] codeNop = 2'b11;      // anything else is a packet

	typedef enum logic [1:0] {
		kindPacket,
		kindRegWrite,
		kindNop
	} wordKindE;

	// register write as the host packs it
	typedef struct packed {
		logic [1:0] kind;       // codeRegWrite
		logic spare;
		logic [4:0] regId;      // target register number
		logic [7:0] pad;
		logic [15:0] regData;   // value to store
	} hostRegWordT;

	// decoded register write for the register block
	typedef struct packed {
		logic [4:0] regId;
		logic [15:0] regData;
	} regWriteT;

	// --------------------------------------------------
	// configuration registers
	// --------------------------------------------------

	typedef struct packed {
		logic [13:0] reserved;
		logic loopback;     // bit 1, serializer feeds deserializer
		logic linkEnable;   // bit 0, outbound link may start words
	} controlRegT;

	localparam logic [4:0] regControl = 5'd0;
	localparam logic [4:0] regSoftReset = 5'd31;   // any write flushes the queues

	localparam int queueDepth = 8;   // words in each pipe queue

	// sort a pipe-in word by its top two bits
	function automatic wordKindE wordKind(input logic [31:0] word);
		case (word[31:30])
			codeRegWrite: return kindRegWrite;
			codeNop: return kindNop;
			default: return kindPacket;
		endcase
	endfunction

endpackage

/* rtl/hostRegisters.sv */
`timescale 1ns/1ps

module hostRegisters (
	input logic sysClk,
	input logic rstN,
	input logic regWrite,
	input hostPkg::regWriteT regWord,
	output logic linkEnable,
	output logic loopback,
	output logic softReset
);

	hostPkg::controlRegT controlReg;
	logic hitControl;
	logic hitSoftReset;

	// address match
	assign hitControl = regWrite && (regWord.regId == hostPkg::regControl);
	assign hitSoftReset = regWrite && (regWord.regId == hostPkg::regSoftReset);

	// --------------------------------------------------
	// control register and soft reset pulse
	// --------------------------------------------------

	always_ff @(posedge sysClk) begin
		if (!rstN) begin
			controlReg <= '0;   // link off, loopback off
			softReset <= 1'b0;
		end else begin
			softReset <= hitSoftReset;   // single cycle, one per write
			if (hitControl) begin
				controlReg <= hostPkg::controlRegT'(regWord.regData);
			end
			// other register numbers fall through untouched
		end
	end

	assign linkEnable = controlReg.linkEnable;
	assign loopback = controlReg.loopback;

endmodule

/* rtl/hostWordDecoder.sv */
`timescale 1ns/1ps

module hostWordDecoder (
	input logic sysClk,
	input logic rstN,
	input logic pipeInWrite,
	input logic [31:0] pipeInData,
	output logic regWrite,
	output hostPkg::regWriteT regWord,
	output logic packetPush,
	output logic [31:0] packetData
);

	hostPkg::hostRegWordT inWord;   // same word seen as a register write
	hostPkg::wordKindE inKind;

	assign inWord = hostPkg::hostRegWordT'(pipeInData);
	assign inKind = hostPkg::wordKind(pipeInData);

	// --------------------------------------------------
	// strobes, one cycle after the pipe write
	// --------------------------------------------------

	always_ff @(posedge sysClk) begin
		if (!rstN) begin
			regWrite <= 1'b0;
			packetPush <= 1'b0;
		end else begin
			// nops raise neither strobe
			regWrite <= pipeInWrite && (inKind == hostPkg::kindRegWrite);
			packetPush <= pipeInWrite && (inKind == hostPkg::kindPacket);
		end
	end

	// --------------------------------------------------
	// payload capture
	// --------------------------------------------------

	always_ff @(posedge sysClk) begin
		if (pipeInWrite) begin
			regWord.regId <= inWord.regId;       // bits 28:24
			regWord.regData <= inWord.regData;   // bits 15:0
			packetData <= pipeInData;            // whole word goes out as flits
		end
	end

endmodule

/* rtl/linkPkg.sv */
package linkPkg;

	// --------------------------------------------------
	// board link flit format
	// --------------------------------------------------

	localparam int flitWidth = 11;      // payload bits per flit
	localparam int flitsPerWord = 3;    // one 32-bit word per three flits

	// accumulator width on the receive side, top bit is spare
	localparam int linkBits = flitWidth * flitsPerWord;

	// flit index within a word
	localparam int flitIdxWidth = $clog2(flitsPerWord);
	typedef logic [flitIdxWidth-1:0] flitIdxT;
	localparam flitIdxT lastFlit = flitIdxT'(flitsPerWord - 1);

	// one flit on the wire, ready travels the other way
	typedef struct packed {
		logic [flitWidth-1:0] data;
		logic valid;
	} flitT;

endpackage

/* rtl/wordFifo.sv */
`timescale 1ns/1ps

module wordFifo #(
	parameter int depth = hostPkg::queueDepth
) (
	input logic sysClk,
	input logic rstN,
	input logic flush,
	input logic push,
	input logic [31:0] pushData,
	input logic pop,
	output logic [31:0] headData,
	output logic empty,
	output logic full
);

	logic [31:0] mem [depth];
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth):0] count;   // 0 to depth
	logic doPush;
	logic doPop;

	assign empty = (count == 0);
	assign full = (count == depth);
	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign headData = mem[rdPtr];   // head visible the cycle after its push

	// pointers and fill count
	always_ff @(posedge sysClk) begin
		if (!rstN || flush) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

	always_ff @(posedge sysClk) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	// producers and consumers look at full and empty before strobing
	noOverflow: assert property (@(posedge sysClk) disable iff (!rstN) push && !flush |-> !full);
	noUnderflow: assert property (@(posedge sysClk) disable iff (!rstN) pop && !flush |-> !empty);

endmodule

/* sim.f */
rtl/hostPkg.sv
rtl/linkPkg.sv
rtl/hostWordDecoder.sv
rtl/hostRegisters.sv
rtl/wordFifo.sv
rtl/flitSerializer.sv
rtl/flitDeserializer.sv
rtl/hostCore.sv
testbench/hostCoreTb.sv

/* testbench/hostCoreTb.sv */
`timescale 1ns/1ps

module hostCoreTb;

	// word counts per test, they size the timeout
	localparam int test1Words = 12;
	localparam int test2Words = 20;
	localparam int test3Words = 9;
	localparam int test4Words = 12;
	localparam int test5Words = 6;
	localparam int test6Words = 9;
	localparam int timeoutCycles = (test1Words + test2Words + test3Words + test4Words
		+ test5Words + test6Words) * linkPkg::flitsPerWord * 8;   // 8x for back-pressure

	logic sysClk;
	logic rstN;
	logic pipeInWrite;
	logic [31:0] pipeInData;
	logic pipeOutRead;
	logic topOutReady;
	linkPkg::flitT topIn;
	logic pipeInReady;
	logic [31:0] pipeOutData;
	logic pipeOutEmpty;
	linkPkg::flitT topOut;
	logic topInReady;

	integer seed;
	int errorCount;
	int markErrors;   // errors before the current test
	int testCount;
	int cycleCount;
	logic readyRandom;   // 0 holds topOutReady low
	logic loopbackOn;    // model routes packets to the pipe-out side
	logic [linkPkg::flitWidth-1:0] expFlits[$];
	logic [31:0] expWords[$];

	hostCore uut (.sysClk, .rstN, .pipeInWrite, .pipeInData, .pipeOutRead, .topOutReady,
		.topIn, .pipeInReady, .pipeOutData, .pipeOutEmpty, .topOut, .topInReady);

	always #20 sysClk = ~sysClk;

	// --------------------------------------------------
	// model helpers
	// --------------------------------------------------

	function automatic logic randBit();
		logic [31:0] r;
		r = $random(seed);
		return r[0];
	endfunction

	// packets keep bit 31 low, so 10 and 11 never show up in 31:30
	function automatic logic [31:0] randPacket();
		logic [31:0] w;
		w = $random(seed);
		w[31] = 1'b0;
		return w;
	endfunction

	function automatic logic [31:0] regWordOf(input logic [4:0] id, input logic [15:0] data);
		return {2'b10, 1'b0, id, 8'h00, data};   // id in 28:24, data in 15:0
	endfunction

	// split rule, least-significant flit first
	function automatic logic [linkPkg::flitWidth-1:0] flitOf(input logic [31:0] word,
		input int idx);
		case (idx)
			0: return word[10:0];
			1: return word[21:11];
			default: return {1'b0, word[31:22]};
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("test %0d (%s) finished with %0d errors", testCount, name,
			errorCount - markErrors);
		markErrors = errorCount;
	endtask

	// --------------------------------------------------
	// host and link drivers
	// --------------------------------------------------

	// one-cycle write strobe from the next rising edge
	task automatic driveWrite(input logic [31:0] word);
		@(posedge sysClk);
		pipeInWrite <= 1'b1;
		pipeInData <= word;
		@(posedge sysClk);
		pipeInWrite <= 1'b0;
	endtask

	task automatic hostWrite(input logic [31:0] word);
		@(negedge sysClk);
		while (!pipeInReady) @(negedge sysClk);   // host honours pipeInReady
		driveWrite(word);
	endtask

	task automatic writePacket(input logic [31:0] word);
		int i;
		hostWrite(word);
		if (loopbackOn) begin
			expWords.push_back(word);   // comes back whole on pipe-out
		end else begin
			for (i = 0; i < linkPkg::flitsPerWord; i++) expFlits.push_back(flitOf(word, i));
		end
	endtask

	// one word as three inbound flits, valid stays up once raised
	task automatic sendInbound(input logic [31:0] word);
		int i;
		logic done;
		logic [linkPkg::flitWidth-1:0] f;
		@(posedge sysClk);
		for (i = 0; i < linkPkg::flitsPerWord; i++) begin
			f = flitOf(word, i);
			if (i == linkPkg::flitsPerWord - 1) f[10] = randBit();   // spare bit, dropped
			topIn <= '{data: f, valid: randBit()};
			done = 1'b0;
			while (!done) begin
				@(negedge sysClk);
				done = topIn.valid && topInReady;   // transfer on the coming edge
				@(posedge sysClk);
				if (!done && !topIn.valid) topIn.valid <= randBit();
			end
		end
		topIn.valid <= 1'b0;
		expWords.push_back(word);
	endtask

	task automatic readWords(input int count);
		int got;
		logic taken;
		logic [31:0] dropped;
		got = 0;
		taken = 1'b0;
		while (got < count) begin
			@(posedge sysClk);
			if (taken) dropped = expWords.pop_front();   // model pops with the queue
			pipeOutRead <= randBit();
			@(negedge sysClk);
			taken = pipeOutRead && !pipeOutEmpty;   // pop on the next edge
			if (taken) begin
				if (expWords.size() == 0) begin
					$display("pipe-out word at %0t when none was expected", $time);
					errorCount++;
					taken = 1'b0;
				end else begin
					checkValue("pipeOutData", pipeOutData, expWords[0]);
				end
				got++;
			end
		end
		@(posedge sysClk);
		if (taken) dropped = expWords.pop_front();
		pipeOutRead <= 1'b0;
	endtask

	task automatic drainFlits();
		while (expFlits.size() != 0) @(negedge sysClk);
		repeat (10) @(negedge sysClk);   // extra flits would show up here
	endtask

	// --------------------------------------------------
	// monitors and timeout
	// --------------------------------------------------

	always @(posedge sysClk) topOutReady <= readyRandom ? randBit() : 1'b0;

	always @(negedge sysClk) begin
		if (rstN && topOut.valid && topOutReady) begin
			if (expFlits.size() == 0) begin
				$display("unexpected flit %h on topOut at %0t", topOut.data, $time);
				errorCount++;
			end else begin
				checkValue("topOut.data", topOut.data, expFlits.pop_front());
			end
		end
		if (rstN && loopbackOn && topOut.valid) begin
			$display("topOutValid raised during loopback at %0t", $time);
			errorCount++;
		end
		if (rstN && expWords.size() == 0) checkValue("pipeOutEmpty", pipeOutEmpty, 1);
	end

	always @(posedge sysClk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout, run stopped after %0d cycles", cycleCount);
			$display("Done: errors found");
			$finish;
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		logic [31:0] r;
		int i;
		seed = 32'h3a44;
		sysClk = 1'b0;
		rstN = 1'b0;
		pipeInWrite = 1'b0;
		pipeInData = '0;
		pipeOutRead = 1'b0;
		topOutReady = 1'b0;
		topIn = '0;
		readyRandom = 1'b1;
		loopbackOn = 1'b0;
		errorCount = 0;
		markErrors = 0;
		testCount = 0;
		cycleCount = 0;
		repeat (4) @(posedge sysClk);
		rstN <= 1'b1;

		// link is off after reset, other registers and nops leave no trace
		for (i = 0; i < 4; i++) begin
			r = $random(seed);
			hostWrite(regWordOf(5'd1 + 5'({r} % 30), r[15:0]));
			hostWrite({2'b11, r[29:0]});
			writePacket(randPacket());
		end
		repeat (10) @(negedge sysClk);
		checkValue("topOut.valid", topOut.valid, 0);
		hostWrite(regWordOf(hostPkg::regControl, 16'h0001));
		drainFlits();
		endTest("register writes and nops");

		for (i = 0; i < test2Words; i++) writePacket(randPacket());
		drainFlits();
		endTest("packet order");

		hostWrite(regWordOf(hostPkg::regControl, 16'h0000));
		repeat (3) @(negedge sysClk);
		for (i = 0; i < hostPkg::queueDepth; i++) writePacket(randPacket());
		repeat (2) @(negedge sysClk);
		checkValue("pipeInReady", pipeInReady, 0);   // ninth write would be refused
		driveWrite(regWordOf(hostPkg::regControl, 16'h0001));   // never enters the full queue
		drainFlits();
		endTest("back-pressure to host");

		fork
			for (int k = 0; k < test4Words; k++) sendInbound($random(seed));
			readWords(test4Words);
		join
		repeat (5) @(negedge sysClk);
		checkValue("pipeOutEmpty", pipeOutEmpty, 1);
		endTest("inbound assembly");

		hostWrite(regWordOf(hostPkg::regControl, 16'h0003));   // link on, loopback on
		repeat (3) @(negedge sysClk);
		loopbackOn = 1'b1;
		checkValue("topInReady", topInReady, 0);
		fork
			for (int k = 0; k < test5Words; k++) writePacket(randPacket());
			readWords(test5Words);
		join
		repeat (5) @(negedge sysClk);
		checkValue("pipeOutEmpty", pipeOutEmpty, 1);
		hostWrite(regWordOf(hostPkg::regControl, 16'h0001));
		repeat (3) @(negedge sysClk);
		loopbackOn = 1'b0;
		endTest("loopback");

		readyRandom = 1'b0;   // first word stalls on the wire
		for (i = 0; i < 5; i++) writePacket(randPacket());
		for (i = 0; i < 3; i++) sendInbound($random(seed));
		repeat (5) @(negedge sysClk);
		checkValue("pipeOutEmpty", pipeOutEmpty, 0);
		checkValue("topOut.valid", topOut.valid, 1);
		r = $random(seed);
		hostWrite(regWordOf(hostPkg::regSoftReset, r[15:0]));
		repeat (3) @(negedge sysClk);   // flush lands two edges after the write
		expFlits.delete();
		expWords.delete();
		checkValue("pipeOutEmpty", pipeOutEmpty, 1);
		checkValue("topOut.valid", topOut.valid, 0);
		readyRandom = 1'b1;
		repeat (20) @(negedge sysClk);
		writePacket(randPacket());   // link enable survived the soft reset
		drainFlits();
		endTest("soft reset");

		$display("tests run %0d, errors %0d", testCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
